// ==== verilog/board_pkg.sv ====
// Board controller definitions

package board_pkg;

  ////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////

  localparam int unsigned ApbAddrWidth = 12;
  localparam int unsigned ApbDataWidth = 32;

  typedef logic [ApbAddrWidth-1:0] apb_addr_t;
  typedef logic [ApbDataWidth-1:0] apb_data_t;

  ////////////////////////////////////////
  // Board signal widths
  ////////////////////////////////////////

  localparam int unsigned LedCount      = 8;
  localparam int unsigned FanLevelWidth = 4;
  localparam int unsigned BootModeWidth = 2;

  typedef logic [LedCount-1:0]      led_t;
  typedef logic [FanLevelWidth-1:0] fan_level_t;
  typedef logic [BootModeWidth-1:0] boot_mode_t;

  // Boot-mode register holds the select in bit 0 and the mode above it
  localparam int unsigned BootSelBit  = 0;
  localparam int unsigned BootModeLsb = 1;

  typedef logic [BootModeWidth:0] boot_reg_t;

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  localparam apb_addr_t RegLed         = 12'h000;
  localparam apb_addr_t RegFanCtl      = 12'h004;
  localparam apb_addr_t RegFanOverride = 12'h008;
  localparam apb_addr_t RegBootMode    = 12'h00C;

  ////////////////////////////////////////
  // Timing
  ////////////////////////////////////////

  // 50 MHz soc_clk divided by 50 gives the 1 MHz RTC
  localparam int unsigned RtcHalfPeriod = 25;
  localparam int unsigned RtcCountWidth = 5;

  typedef logic [RtcCountWidth-1:0] rtc_count_t;

  // One PWM period is FanStepCycles * FanStepsPerPeriod cycles
  localparam int unsigned FanStepCycles     = 4;
  localparam int unsigned FanStepsPerPeriod = 15;
  localparam int unsigned FanPeriodCycles   = FanStepCycles * FanStepsPerPeriod;

  typedef logic [$clog2(FanStepCycles)-1:0] fan_prescale_t;

endpackage

// ==== verilog/apb_if.sv ====
// APB bus interface

`timescale 1ns/10ps

interface apb_if import board_pkg::*; ();

  apb_addr_t paddr;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;

  // Requester side
  modport master (
    output paddr,
    output psel,
    output penable,
    output pwrite,
    output pwdata,
    input  prdata,
    input  pready,
    input  pslverr
  );

  // Completer side
  modport slave (
    input  paddr,
    input  psel,
    input  penable,
    input  pwrite,
    input  pwdata,
    output prdata,
    output pready,
    output pslverr
  );

endinterface

// ==== verilog/board_regs.sv ====
// Board control register block

`timescale 1ns/10ps

module board_regs import board_pkg::*; (
  input  logic       soc_clk,
  input  logic       rst_n,
  apb_if.slave       bus,
  input  fan_level_t fan_sw_i,
  input  boot_mode_t boot_mode_i,
  output led_t       led_o,
  output fan_level_t fan_level_o,
  output boot_mode_t boot_mode_o
);

  ////////////////////////////////////////
  // Transfer decode
  ////////////////////////////////////////

  logic      access;
  logic      wr_en;
  logic      addr_hit;
  apb_data_t rdata;

  led_t       led_q;
  fan_level_t fan_ctl_q;
  logic       override_q;
  boot_reg_t  boot_q;

  // Zero wait states so every access phase completes
  assign access = bus.psel & bus.penable;
  assign wr_en  = access & bus.pwrite;

  always_comb begin
    addr_hit = 1'b1;
    rdata    = '0;
    case (bus.paddr)
      RegLed:         rdata = apb_data_t'(led_q);
      RegFanCtl:      rdata = apb_data_t'(fan_ctl_q);
      RegFanOverride: rdata = apb_data_t'(override_q);
      RegBootMode:    rdata = apb_data_t'(boot_q);
      default: begin
        // Unmapped offset reads as zero
        addr_hit = 1'b0;
      end
    endcase
  end

  assign bus.prdata  = rdata;
  assign bus.pready  = access;
  assign bus.pslverr = access & ~addr_hit;

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      led_q      <= '0;
      override_q <= 1'b0;
      boot_q     <= '0;
    end else if (wr_en) begin
      case (bus.paddr)
        RegLed:         led_q      <= bus.pwdata[LedCount-1:0];
        RegFanOverride: override_q <= bus.pwdata[0];
        RegBootMode:    boot_q     <= bus.pwdata[BootModeWidth:0];
        default: begin
          // Fan level is handled below and bad offsets are ignored
        end
      endcase
    end
  end

  // Fan level mirrors the switches until software takes over
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      fan_ctl_q <= '0;
    end else if (!override_q) begin
      fan_ctl_q <= fan_sw_i;
    end else if (wr_en && (bus.paddr == RegFanCtl)) begin
      fan_ctl_q <= bus.pwdata[FanLevelWidth-1:0];
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  assign led_o       = led_q;
  assign fan_level_o = fan_ctl_q;

  // Register mode wins over the pins when selected
  assign boot_mode_o = boot_q[BootSelBit] ?
                       boot_q[BootModeLsb +: BootModeWidth] : boot_mode_i;

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  // Master must hold psel through the access phase
  penable_needs_psel: assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    bus.penable |-> bus.psel
  ) else $error("penable high without psel");

  // A write that gets an error response leaves the registers alone
  bad_write_ignored: assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    (bus.pslverr && bus.pwrite) |=> $stable({led_q, override_q, boot_q})
  ) else $error("write to an unmapped offset changed a register");

endmodule

// ==== verilog/fan_pwm.sv ====
// Fan PWM generator

`timescale 1ns/10ps

module fan_pwm import board_pkg::*; (
  input  logic       soc_clk,
  input  logic       rst_n,
  input  fan_level_t level_i,
  output logic       fan_pwm_o
);

  fan_prescale_t presc_q;
  fan_level_t    step_q;
  fan_level_t    level_q;
  logic          step_end;
  logic          period_end;

  ////////////////////////////////////////
  // Period counters
  ////////////////////////////////////////

  assign step_end   = (presc_q == fan_prescale_t'(FanStepCycles - 1));
  assign period_end = step_end && (step_q == fan_level_t'(FanStepsPerPeriod - 1));

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      presc_q <= '0;
      step_q  <= '0;
    end else begin
      if (step_end) begin
        presc_q <= '0;
      end else begin
        presc_q <= presc_q + 1'b1;
      end
      if (period_end) begin
        step_q <= '0;
      end else if (step_end) begin
        step_q <= step_q + 1'b1;
      end
    end
  end

  // New level only at a period boundary, so no period is cut short
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      level_q <= '0;
    end else if (period_end) begin
      level_q <= level_i;
    end
  end

  ////////////////////////////////////////
  // Output
  ////////////////////////////////////////

  // High from the first step of the period for level_q steps
  assign fan_pwm_o = (step_q < level_q);

  // A zero level keeps the fan off for the whole next period
  zero_level_off: assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    (period_end && (level_i == '0)) |=> !fan_pwm_o [*FanPeriodCycles]
  ) else $error("fan_pwm_o high during a zero-level period");

endmodule

// ==== verilog/rtc_divider.sv ====
// Real-time clock divider

`timescale 1ns/10ps

module rtc_divider import board_pkg::*; (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  rtc_count_t count_q;
  logic       wrap;
  logic       rtc_q;

  assign wrap = (count_q == rtc_count_t'(RtcHalfPeriod - 1));

  // Toggle once per half period
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
      rtc_q   <= 1'b0;
    end else if (wrap) begin
      count_q <= '0;
      rtc_q   <= ~rtc_q;
    end else begin
      count_q <= count_q + 1'b1;
    end
  end

  assign rtc_o = rtc_q;

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  count_in_range: assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    count_q <= rtc_count_t'(RtcHalfPeriod - 1)
  ) else $error("RTC counter out of range: %0d", count_q);

endmodule

// ==== verilog/board_ctrl_top.sv ====
// Board controller top level

`timescale 1ns/10ps

module board_ctrl_top import board_pkg::*; (
  input  logic       soc_clk,
  input  logic       rst_n,

  // APB completer port
  input  apb_addr_t  paddr_i,
  input  logic       psel_i,
  input  logic       penable_i,
  input  logic       pwrite_i,
  input  apb_data_t  pwdata_i,
  output apb_data_t  prdata_o,
  output logic       pready_o,
  output logic       pslverr_o,

  // Board pins
  input  fan_level_t fan_sw_i,
  input  boot_mode_t boot_mode_i,
  output led_t       led_o,
  output boot_mode_t boot_mode_o,
  output logic       fan_pwm_o,
  output logic       rtc_o
);

  ////////////////////////////////////////
  // APB binding
  ////////////////////////////////////////

  apb_if apb ();

  assign apb.paddr   = paddr_i;
  assign apb.psel    = psel_i;
  assign apb.penable = penable_i;
  assign apb.pwrite  = pwrite_i;
  assign apb.pwdata  = pwdata_i;

  assign prdata_o  = apb.prdata;
  assign pready_o  = apb.pready;
  assign pslverr_o = apb.pslverr;

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  fan_level_t fan_level;

  board_regs i_board_regs (
    .soc_clk     ( soc_clk     ),
    .rst_n       ( rst_n       ),
    .bus         ( apb.slave   ),
    .fan_sw_i    ( fan_sw_i    ),
    .boot_mode_i ( boot_mode_i ),
    .led_o       ( led_o       ),
    .fan_level_o ( fan_level   ),
    .boot_mode_o ( boot_mode_o )
  );

  ////////////////////////////////////////
  // Fan control
  ////////////////////////////////////////

  fan_pwm i_fan_pwm (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( rst_n     ),
    .level_i   ( fan_level ),
    .fan_pwm_o ( fan_pwm_o )
  );

  ////////////////////////////////////////
  // RTC
  ////////////////////////////////////////

  // Free-running 1 MHz clock from the 50 MHz soc_clk
  rtc_divider i_rtc_divider (
    .soc_clk ( soc_clk ),
    .rst_n   ( rst_n   ),
    .rtc_o   ( rtc_o   )
  );

endmodule

// ==== bench/board_ctrl_tb.sv ====
// Board controller testbench

`timescale 1ns/10ps

module board_ctrl_tb import board_pkg::*; ();

  localparam int unsigned BusTimeout = 16;
  localparam int unsigned RtcTimeout = 100;
  localparam apb_addr_t   BadOffset  = 12'h010;

  typedef enum logic {OpRead, OpWrite} bus_op_e;

  typedef struct {
    bus_op_e    op;
    apb_addr_t  addr;
    apb_data_t  wdata;
    fan_level_t sw;
    apb_data_t  exp_rdata;
    logic       exp_err;
  } bus_step_t;

  logic       soc_clk;
  logic       rst_n;
  apb_addr_t  paddr;
  logic       psel;
  logic       penable;
  logic       pwrite;
  apb_data_t  pwdata;
  apb_data_t  prdata;
  logic       pready;
  logic       pslverr;
  fan_level_t fan_sw;
  boot_mode_t boot_pins;
  led_t       led;
  boot_mode_t boot_mode;
  logic       fan_pwm;
  logic       rtc;

  bus_step_t   steps[$];
  apb_data_t   led_val;
  fan_level_t  sw_a;
  fan_level_t  sw_b;
  fan_level_t  sw_c;
  fan_level_t  sw_d;
  apb_data_t   rdata;
  logic        err;
  int unsigned cycles;
  int unsigned high_cycles;

  board_ctrl_top board_ctrl_top_i (
    .soc_clk     ( soc_clk   ),
    .rst_n       ( rst_n     ),
    .paddr_i     ( paddr     ),
    .psel_i      ( psel      ),
    .penable_i   ( penable   ),
    .pwrite_i    ( pwrite    ),
    .pwdata_i    ( pwdata    ),
    .prdata_o    ( prdata    ),
    .pready_o    ( pready    ),
    .pslverr_o   ( pslverr   ),
    .fan_sw_i    ( fan_sw    ),
    .boot_mode_i ( boot_pins ),
    .led_o       ( led       ),
    .boot_mode_o ( boot_mode ),
    .fan_pwm_o   ( fan_pwm   ),
    .rtc_o       ( rtc       )
  );

  initial begin
    soc_clk = 1'b0;
    forever #5 soc_clk = ~soc_clk;
  end

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
      $display("tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("tests failed");
    $fatal(1, "timeout");
  endtask

  ////////////////////////////////////////
  // APB master
  ////////////////////////////////////////

  task automatic apb_transfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rd, output logic slv_err);
    int unsigned waited;
    @(negedge soc_clk);
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge soc_clk);
    check_value("pready_o in setup phase", pready, 1'b0);
    @(negedge soc_clk);
    penable = 1'b1;
    waited  = 0;
    @(posedge soc_clk);
    while (!pready) begin
      if (waited == BusTimeout) report_timeout("pready_o never rose in the access phase");
      waited++;
      @(posedge soc_clk);
    end
    rd      = prdata;
    slv_err = pslverr;
    @(negedge soc_clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata, output logic slv_err);
    apb_data_t unused;
    apb_transfer(1'b1, addr, wdata, unused, slv_err);
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t rd, output logic slv_err);
    apb_transfer(1'b0, addr, '0, rd, slv_err);
  endtask

  ////////////////////////////////////////
  // Measurements
  ////////////////////////////////////////

  // Falling edges until rtc_o reaches the given level
  task automatic wait_rtc_level(input logic level, output int unsigned count);
    count = 0;
    do begin
      @(negedge soc_clk);
      count++;
      if (count > RtcTimeout) report_timeout(level ? "rtc_o never rose" : "rtc_o never fell");
    end while (rtc !== level);
  endtask

  task automatic measure_duty(input fan_level_t level);
    logic slv_err;
    int unsigned count;
    apb_write(RegFanCtl, apb_data_t'(level), slv_err);
    // Let the new level reach a period boundary
    repeat (2 * FanPeriodCycles) @(negedge soc_clk);
    count = 0;
    repeat (FanPeriodCycles) begin
      @(negedge soc_clk);
      if (fan_pwm) count++;
    end
    check_value("fan_pwm_o high cycles", count, level * FanStepCycles);
  endtask

  task automatic add_step(input bus_op_e op, input apb_addr_t addr, input apb_data_t wdata,
                          input fan_level_t sw, input apb_data_t exp_rdata, input logic exp_err);
    bus_step_t s;
    s.op        = op;
    s.addr      = addr;
    s.wdata     = wdata;
    s.sw        = sw;
    s.exp_rdata = exp_rdata;
    s.exp_err   = exp_err;
    steps.push_back(s);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    rst_n     = 1'b0;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    fan_sw    = '0;
    boot_pins = '0;
    void'($urandom(47314));

    led_val = $urandom();
    sw_a    = fan_level_t'($urandom());
    sw_b    = fan_level_t'($urandom());
    sw_c    = fan_level_t'($urandom());
    sw_d    = fan_level_t'($urandom());
    if (sw_b == 4'hA) sw_b = 4'h5;
    if (sw_c == sw_b) sw_c = ~sw_b;
    if (sw_d == 4'hC) sw_d = 4'h3;

    repeat (10) @(negedge soc_clk);
    check_value("led_o", led, 0);
    check_value("boot_mode_o", boot_mode, 0);
    check_value("fan_pwm_o", fan_pwm, 0);
    check_value("rtc_o", rtc, 0);
    check_value("pready_o", pready, 0);
    check_value("pslverr_o", pslverr, 0);
    rst_n = 1'b1;

    // RTC first rise, then high and low times
    wait_rtc_level(1'b1, cycles);
    check_value("rtc_o first rise cycles", cycles, RtcHalfPeriod);
    wait_rtc_level(1'b0, high_cycles);
    check_value("rtc_o high cycles", high_cycles, RtcHalfPeriod);
    wait_rtc_level(1'b1, cycles);
    check_value("rtc_o rise to rise cycles", high_cycles + cycles, 2 * RtcHalfPeriod);

    // op, offset, write data, switches, expected read data, expected pslverr
    add_step(OpWrite, RegLed,         led_val,          sw_a, '0,                      1'b0);
    add_step(OpRead,  RegLed,         '0,               sw_a, led_val & 32'hFF,        1'b0);
    add_step(OpWrite, RegBootMode,    32'hFFFF_FFF5,    sw_a, '0,                      1'b0);
    add_step(OpRead,  RegBootMode,    '0,               sw_a, 32'h5,                   1'b0);
    add_step(OpRead,  RegFanOverride, '0,               sw_a, 32'h0,                   1'b0);
    add_step(OpRead,  RegFanCtl,      '0,               sw_a, apb_data_t'(sw_a),       1'b0);
    add_step(OpWrite, RegFanCtl,      32'hA,            sw_b, '0,                      1'b0);
    add_step(OpRead,  RegFanCtl,      '0,               sw_b, apb_data_t'(sw_b),       1'b0);
    add_step(OpWrite, RegFanOverride, 32'hFFFF_FFFF,    sw_b, '0,                      1'b0);
    add_step(OpRead,  RegFanOverride, '0,               sw_c, 32'h1,                   1'b0);
    add_step(OpRead,  RegFanCtl,      '0,               sw_c, apb_data_t'(sw_b),       1'b0);
    add_step(OpWrite, RegFanCtl,      32'h3C,           sw_c, '0,                      1'b0);
    add_step(OpRead,  RegFanCtl,      '0,               sw_d, 32'hC,                   1'b0);
    add_step(OpWrite, BadOffset,      32'hFFFF_FFFF,    sw_d, '0,                      1'b1);
    add_step(OpRead,  BadOffset,      '0,               sw_d, '0,                      1'b1);
    add_step(OpRead,  RegLed,         '0,               sw_a, led_val & 32'hFF,        1'b0);
    add_step(OpRead,  RegFanCtl,      '0,               sw_a, 32'hC,                   1'b0);
    add_step(OpRead,  RegFanOverride, '0,               sw_a, 32'h1,                   1'b0);
    add_step(OpRead,  RegBootMode,    '0,               sw_a, 32'h5,                   1'b0);

    foreach (steps[i]) begin
      fan_sw = steps[i].sw;
      if (steps[i].op == OpWrite) begin
        apb_write(steps[i].addr, steps[i].wdata, err);
      end else begin
        apb_read(steps[i].addr, rdata, err);
        check_value($sformatf("prdata_o in step %0d", i), rdata, steps[i].exp_rdata);
      end
      check_value($sformatf("pslverr_o in step %0d", i), err, steps[i].exp_err);
    end

    check_value("led_o", led, led_val & 32'hFF);
    boot_pins = 2'd1;
    @(posedge soc_clk);
    check_value("boot_mode_o with select set", boot_mode, 2'd2);

    // Select clear hands the boot mode back to the pins
    apb_write(RegBootMode, 32'h0, err);
    for (int m = 3; m >= 0; m--) begin
      @(negedge soc_clk);
      boot_pins = boot_mode_t'(m);
      @(posedge soc_clk);
      check_value("boot_mode_o following pins", boot_mode, m);
    end
    apb_write(RegBootMode, 32'h7, err);
    @(posedge soc_clk);
    check_value("boot_mode_o with select set", boot_mode, 2'd3);

    measure_duty(4'd0);
    measure_duty(4'd7);
    measure_duty(4'd15);

    $display("all tests passed");
    $finish;
  end

endmodule

// ==== filelist.f ====
verilog/board_pkg.sv
verilog/apb_if.sv
verilog/board_regs.sv
verilog/fan_pwm.sv
verilog/rtc_divider.sv
verilog/board_ctrl_top.sv
bench/board_ctrl_tb.sv
